//--- tb.f
verilog/cpu_pkg.sv
verilog/control_decode.sv
verilog/register_bank.sv
verilog/alu.sv
verilog/address_unit.sv
verilog/ram.sv
verilog/bus_mux.sv
verilog/cpu.sv
testbench/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) $(VFLAGS)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int EDGE_LIMIT = 8;

    logic       clk;
    logic       rst_n;
    ctrl_word_t ctrl_word;
    logic       ctrl_en;
    byte_t      data_in;
    addr_t      addr_in;
    logic       out_rst;
    byte_t      main_bus;
    addr_t      addr_bus;
    byte_t      out_port;
    logic       carry;
    logic       zero;

    int    errors;
    int    seed;
    bit    timed_out;
    string test_name;

    // Reference model state
    byte_t m_a;
    byte_t m_b;
    byte_t m_out;
    addr_t m_mar;
    logic  m_carry;
    logic  m_zero;
    byte_t m_ram [RAM_DEPTH];
    bit    m_known [RAM_DEPTH];

    cpu i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (timed_out) return;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // Returns on the requested clock level change
    task automatic wait_edge(input logic level);
        int events;
        events = 0;
        if (timed_out) return;
        do begin
            @(clk);
            events++;
        end while (clk !== level && events < EDGE_LIMIT);
        if (clk !== level) begin
            timed_out = 1'b1;
            $display("Timed out: no clock edge within %0d clock events", EDGE_LIMIT);
        end
    endtask

    function automatic ctrl_word_t bit_at(input int pos);
        return ctrl_word_t'(1) << pos;
    endfunction

    function automatic ctrl_word_t build_word(input bus_src_e src, input alu_op_e op,
                                              input ctrl_word_t strobes);
        ctrl_word_t w;
        w = strobes;
        w[CW_BUS_SRC_LSB +: CW_BUS_SRC_W] = src;
        w[CW_ALU_OP_LSB +: CW_ALU_OP_W] = op;
        return w;
    endfunction

    function automatic byte_t rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // {carry, result}
    function automatic logic [8:0] alu_model(input alu_op_e op, input byte_t a, input byte_t b);
        case (op)
            ALU_ADD: return {1'b0, a} + {1'b0, b};
            ALU_SUB: return {a < b, a - b};
            ALU_AND: return {1'b0, a & b};
            ALU_OR:  return {1'b0, a | b};
            ALU_XOR: return {1'b0, a ^ b};
            ALU_SHL: return {a[7], a << 1};
            ALU_SHR: return {a[0], a >> 1};
            default: return {1'b0, b};
        endcase
    endfunction

    function automatic byte_t bus_model(input ctrl_word_t w, input logic en, input byte_t d,
                                        input logic [RAM_ADDR_BITS-1:0] idx);
        logic [8:0] alu_out;
        alu_out = alu_model(alu_op_e'(w[CW_ALU_OP_LSB +: CW_ALU_OP_W]), m_a, m_b);
        if (!en) return 8'h00;
        case (w[CW_BUS_SRC_LSB +: CW_BUS_SRC_W])
            BUS_EXT:    return d;
            BUS_A:      return m_a;
            BUS_B:      return m_b;
            BUS_ALU:    return alu_out[7:0];
            BUS_RAM:    return m_ram[idx];
            BUS_MAR_LO: return m_mar[7:0];
            BUS_MAR_HI: return m_mar[15:8];
            BUS_OUT:    return m_out;
            default:    return 8'h00;
        endcase
    endfunction

    // Applies one word, checks outputs mid-cycle, then advances the model
    task automatic step(input ctrl_word_t w, input byte_t d = 8'h00, input addr_t a = 16'h0000,
                        input logic en = 1'b1, input logic orst = 1'b0);
        byte_t                    exp_bus;
        addr_t                    exp_addr;
        logic [8:0]               alu_out;
        logic [RAM_ADDR_BITS-1:0] idx;
        wait_edge(1'b1);
        ctrl_word <= w;
        data_in   <= d;
        addr_in   <= a;
        ctrl_en   <= en;
        out_rst   <= orst;
        wait_edge(1'b0);
        exp_addr = (en && w[CW_RAM_ADDR_EXT]) ? a : m_mar;
        idx      = exp_addr[RAM_ADDR_BITS-1:0];
        exp_bus  = bus_model(w, en, d, idx);
        alu_out  = alu_model(alu_op_e'(w[CW_ALU_OP_LSB +: CW_ALU_OP_W]), m_a, m_b);
        if (!(en && w[CW_BUS_SRC_LSB +: CW_BUS_SRC_W] == BUS_RAM && !m_known[idx])) begin
            check("main_bus", 16'(exp_bus), 16'(main_bus));
        end
        check("addr_bus", exp_addr, addr_bus);
        check("carry", 16'(m_carry), 16'(carry));
        check("zero", 16'(m_zero), 16'(zero));
        check("out_port", 16'(m_out), 16'(out_port));
        if (orst) begin
            m_out = 8'h00;
        end else if (en && w[CW_LOAD_OUT]) begin
            m_out = exp_bus;
        end
        if (!en) return;
        if (w[CW_LOAD_A]) m_a = exp_bus;
        if (w[CW_LOAD_B]) m_b = exp_bus;
        if (w[CW_LOAD_FLAGS]) begin
            m_carry = alu_out[8];
            m_zero  = (alu_out[7:0] == 8'h00);
        end
        if (w[CW_RAM_WE]) begin
            m_ram[idx]   = exp_bus;
            m_known[idx] = 1'b1;
        end
        if (w[CW_MAR_EXT]) begin
            m_mar = a;
        end else if (w[CW_MAR_LO] || w[CW_MAR_HI]) begin
            if (w[CW_MAR_LO]) m_mar[7:0] = exp_bus;
            if (w[CW_MAR_HI]) m_mar[15:8] = exp_bus;
        end else if (w[CW_MAR_INC]) begin
            m_mar = m_mar + 16'd1;
        end
    endtask

    task automatic reset_sequence();
        test_name = "reset_sequence";
        step(build_word(BUS_A, ALU_ADD, '0));
        check("A after reset", 16'h0000, 16'(main_bus));
        step(build_word(BUS_B, ALU_ADD, '0));
        check("B after reset", 16'h0000, 16'(main_bus));
        step(build_word(BUS_MAR_LO, ALU_ADD, '0));
        check("MAR after reset", 16'h0000, 16'(main_bus));
        step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_LOAD_A)), 8'd24);
        step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_LOAD_B)), 8'd18);
        step(build_word(BUS_ALU, ALU_ADD, bit_at(CW_LOAD_A) | bit_at(CW_LOAD_FLAGS)));
        step(build_word(BUS_A, ALU_ADD, '0));
        check("A after add", 16'd42, 16'(main_bus));
        check("carry after add", 16'h0000, 16'(carry));
        check("zero after add", 16'h0000, 16'(zero));
    endtask

    task automatic alu_ops();
        byte_t a;
        byte_t b;
        test_name = "alu_ops";
        for (int i = 0; i < 40; i++) begin
            a = rand_byte();
            b = rand_byte();
            // Equal operands now and then so the zero flag gets set
            if (i % 8 == 0) b = a;
            step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_LOAD_A)), a);
            step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_LOAD_B)), b);
            for (int op = 0; op < 8; op++) begin
                step(build_word(BUS_ALU, alu_op_e'(op[2:0]), bit_at(CW_LOAD_FLAGS)));
            end
        end
        step(build_word(BUS_NONE, ALU_ADD, '0));
    endtask

    task automatic ram_ext();
        addr_t      addrs [16];
        byte_t      vals [16];
        logic [15:0] r;
        ctrl_word_t wr;
        ctrl_word_t rd;
        test_name = "ram_ext";
        wr = build_word(BUS_EXT, ALU_ADD, bit_at(CW_RAM_ADDR_EXT) | bit_at(CW_RAM_WE));
        rd = build_word(BUS_RAM, ALU_ADD, bit_at(CW_RAM_ADDR_EXT));
        step(wr, 8'h54, 16'h1234);
        check("write address", 16'h1234, addr_bus);
        for (int i = 0; i < 16; i++) begin
            // Distinct low bits, random high bits that alias
            r = 16'($random(seed));
            addrs[i] = {r[15:10], 10'(i * 40 + 8)};
            vals[i] = rand_byte();
            step(wr, vals[i], addrs[i]);
            check("write address", addrs[i], addr_bus);
        end
        step(rd, 8'h00, 16'h1234);
        check("read 0x1234", 16'h0054, 16'(main_bus));
        for (int i = 0; i < 16; i++) begin
            step(rd, 8'h00, addrs[i]);
            check("read back", 16'(vals[i]), 16'(main_bus));
            check("read address", addrs[i], addr_bus);
        end
    endtask

    task automatic mar_ops();
        byte_t vals [4];
        test_name = "mar_ops";
        step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_MAR_LO)), 8'hcd);
        step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_MAR_HI)), 8'hab);
        step(build_word(BUS_MAR_LO, ALU_ADD, '0));
        check("MAR low", 16'h00cd, 16'(main_bus));
        check("MAR on addr_bus", 16'habcd, addr_bus);
        step(build_word(BUS_MAR_HI, ALU_ADD, '0));
        check("MAR high", 16'h00ab, 16'(main_bus));
        step(build_word(BUS_NONE, ALU_ADD, bit_at(CW_MAR_EXT)), 8'h00, 16'h00ff);
        step(build_word(BUS_NONE, ALU_ADD, bit_at(CW_MAR_INC)));
        step(build_word(BUS_NONE, ALU_ADD, '0));
        check("increment past 0x00ff", 16'h0100, addr_bus);
        step(build_word(BUS_NONE, ALU_ADD, bit_at(CW_MAR_EXT)), 8'h00, 16'hffff);
        step(build_word(BUS_NONE, ALU_ADD, bit_at(CW_MAR_INC)));
        step(build_word(BUS_NONE, ALU_ADD, '0));
        check("increment wraps", 16'h0000, addr_bus);
        step(build_word(BUS_NONE, ALU_ADD, bit_at(CW_MAR_EXT)), 8'h00, 16'h0200);
        for (int i = 0; i < 4; i++) begin
            vals[i] = rand_byte();
            step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_RAM_WE) | bit_at(CW_MAR_INC)), vals[i]);
        end
        step(build_word(BUS_NONE, ALU_ADD, bit_at(CW_MAR_EXT)), 8'h00, 16'h0200);
        for (int i = 0; i < 4; i++) begin
            step(build_word(BUS_RAM, ALU_ADD, bit_at(CW_MAR_INC)));
            check("MAR-addressed read", 16'(vals[i]), 16'(main_bus));
        end
    endtask

    task automatic gating_and_out();
        ctrl_word_t all_loads;
        ctrl_word_t to_out;
        test_name = "gating_and_out";
        all_loads = build_word(BUS_EXT, ALU_ADD, bit_at(CW_LOAD_A) | bit_at(CW_LOAD_B) |
                               bit_at(CW_LOAD_OUT) | bit_at(CW_LOAD_FLAGS) |
                               bit_at(CW_MAR_EXT) | bit_at(CW_RAM_WE));
        to_out = build_word(BUS_EXT, ALU_ADD, bit_at(CW_LOAD_OUT));
        step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_LOAD_A)), 8'h3c);
        step(build_word(BUS_EXT, ALU_ADD, bit_at(CW_LOAD_B)), 8'hc3);
        step(build_word(BUS_NONE, ALU_ADD, bit_at(CW_MAR_EXT)), 8'h00, 16'h0155);
        step(all_loads, 8'hff, 16'hffff, 1'b0);
        check("gated bus", 16'h0000, 16'(main_bus));
        step(build_word(BUS_A, ALU_ADD, '0));
        check("A kept", 16'h003c, 16'(main_bus));
        check("MAR kept", 16'h0155, addr_bus);
        step(build_word(BUS_B, ALU_ADD, '0));
        check("B kept", 16'h00c3, 16'(main_bus));
        step(to_out, 8'h5a);
        step(build_word(BUS_OUT, ALU_ADD, '0));
        check("out_port loaded", 16'h005a, 16'(out_port));
        check("out on bus", 16'h005a, 16'(main_bus));
        step(build_word(BUS_NONE, ALU_ADD, '0), 8'h00, 16'h0000, 1'b1, 1'b1);
        step(build_word(BUS_NONE, ALU_ADD, '0));
        check("out_port cleared", 16'h0000, 16'(out_port));
        step(to_out, 8'h77, 16'h0000, 1'b1, 1'b1);
        step(build_word(BUS_NONE, ALU_ADD, '0));
        check("clear beats load", 16'h0000, 16'(out_port));
    endtask

    initial begin
        rst_n     = 1'b0;
        ctrl_word = '0;
        ctrl_en   = 1'b0;
        data_in   = '0;
        addr_in   = '0;
        out_rst   = 1'b0;
        errors    = 0;
        seed      = 32'hc982_d177;
        timed_out = 1'b0;
        test_name = "reset";
        m_a       = '0;
        m_b       = '0;
        m_out     = '0;
        m_mar     = '0;
        m_carry   = 1'b0;
        m_zero    = 1'b0;
        repeat (4) wait_edge(1'b1);
        rst_n <= 1'b1;
        reset_sequence();
        alu_ops();
        ram_ext();
        mar_ops();
        gating_and_out();
        $display("Checks finished with %0d errors", errors);
        if (!timed_out && errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl_word,
    input  logic       ctrl_en,
    input  byte_t      data_in,
    input  addr_t      addr_in,
    input  logic       out_rst,
    output byte_t      main_bus,
    output addr_t      addr_bus,
    output byte_t      out_port,
    output logic       carry,
    output logic       zero
);

    bus_src_e bus_src;
    alu_op_e  alu_op;
    logic     load_a;
    logic     load_b;
    logic     load_out;
    logic     load_flags;
    logic     mar_ext;
    logic     mar_lo;
    logic     mar_hi;
    logic     mar_inc;
    logic     ram_addr_ext;
    logic     ram_we;

    byte_t reg_a;
    byte_t reg_b;
    byte_t alu_result;
    byte_t ram_data;
    addr_t mar;

    control_decode i_decode (
        .ctrl_word   (ctrl_word),
        .ctrl_en     (ctrl_en),
        .bus_src     (bus_src),
        .alu_op      (alu_op),
        .load_a      (load_a),
        .load_b      (load_b),
        .load_out    (load_out),
        .load_flags  (load_flags),
        .mar_ext     (mar_ext),
        .mar_lo      (mar_lo),
        .mar_hi      (mar_hi),
        .mar_inc     (mar_inc),
        .ram_addr_ext(ram_addr_ext),
        .ram_we      (ram_we)
    );

    register_bank i_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .out_rst (out_rst),
        .load_a  (load_a),
        .load_b  (load_b),
        .load_out(load_out),
        .main_bus(main_bus),
        .reg_a   (reg_a),
        .reg_b   (reg_b),
        .out_port(out_port)
    );

    alu i_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_op    (alu_op),
        .load_flags(load_flags),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .alu_result(alu_result),
        .carry     (carry),
        .zero      (zero)
    );

    address_unit i_addr (
        .clk         (clk),
        .rst_n       (rst_n),
        .mar_ext     (mar_ext),
        .mar_lo      (mar_lo),
        .mar_hi      (mar_hi),
        .mar_inc     (mar_inc),
        .ram_addr_ext(ram_addr_ext),
        .addr_in     (addr_in),
        .main_bus    (main_bus),
        .mar         (mar),
        .addr_bus    (addr_bus)
    );

    ram i_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (addr_bus),
        .wdata(main_bus),
        .rdata(ram_data)
    );

    bus_mux i_bus (
        .bus_src   (bus_src),
        .data_in   (data_in),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .alu_result(alu_result),
        .ram_data  (ram_data),
        .mar       (mar),
        .out_port  (out_port),
        .main_bus  (main_bus)
    );

endmodule

`default_nettype wire

//--- verilog/bus_mux.sv
`timescale 1ns/10ps
`default_nettype none

module bus_mux import cpu_pkg::*; (
    input  bus_src_e bus_src,
    input  byte_t    data_in,
    input  byte_t    reg_a,
    input  byte_t    reg_b,
    input  byte_t    alu_result,
    input  byte_t    ram_data,
    input  addr_t    mar,
    input  byte_t    out_port,
    output byte_t    main_bus
);

    always_comb begin
        case (bus_src)
            BUS_EXT:    main_bus = data_in;
            BUS_A:      main_bus = reg_a;
            BUS_B:      main_bus = reg_b;
            BUS_ALU:    main_bus = alu_result;
            BUS_RAM:    main_bus = ram_data;
            BUS_MAR_LO: main_bus = mar[7:0];
            BUS_MAR_HI: main_bus = mar[15:8];
            BUS_OUT:    main_bus = out_port;
            default:    main_bus = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/ram.sv
`timescale 1ns/10ps
`default_nettype none

module ram import cpu_pkg::*; (
    input  logic  clk,
    input  logic  we,
    input  addr_t addr,
    input  byte_t wdata,
    output byte_t rdata
);

    byte_t mem [RAM_DEPTH];

    logic [RAM_ADDR_BITS-1:0] index;

    // High address bits alias
    assign index = addr[RAM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];

endmodule

`default_nettype wire

//--- verilog/address_unit.sv
`timescale 1ns/10ps
`default_nettype none

module address_unit import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mar_ext,
    input  logic  mar_lo,
    input  logic  mar_hi,
    input  logic  mar_inc,
    input  logic  ram_addr_ext,
    input  addr_t addr_in,
    input  byte_t main_bus,
    output addr_t mar,
    output addr_t addr_bus
);

    // External address first, then bus bytes, then increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (mar_ext) begin
            mar <= addr_in;
        end else if (mar_lo || mar_hi) begin
            if (mar_lo) begin
                mar[7:0] <= main_bus;
            end
            if (mar_hi) begin
                mar[15:8] <= main_bus;
            end
        end else if (mar_inc) begin
            mar <= mar + addr_t'(1);
        end
    end

    assign addr_bus = ram_addr_ext ? addr_in : mar;

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  alu_op_e alu_op,
    input  logic    load_flags,
    input  byte_t   reg_a,
    input  byte_t   reg_b,
    output byte_t   alu_result,
    output logic    carry,
    output logic    zero
);

    logic [8:0] wide;
    logic       carry_next;

    always_comb begin
        wide       = '0;
        carry_next = 1'b0;
        unique case (alu_op)
            ALU_ADD: begin
                wide       = {1'b0, reg_a} + {1'b0, reg_b};
                carry_next = wide[8];
            end
            ALU_SUB: begin
                // Top bit set means a borrow
                wide       = {1'b0, reg_a} - {1'b0, reg_b};
                carry_next = wide[8];
            end
            ALU_AND: wide[7:0] = reg_a & reg_b;
            ALU_OR:  wide[7:0] = reg_a | reg_b;
            ALU_XOR: wide[7:0] = reg_a ^ reg_b;
            ALU_SHL: begin
                wide[7:0]  = {reg_a[6:0], 1'b0};
                carry_next = reg_a[7];
            end
            ALU_SHR: begin
                wide[7:0]  = {1'b0, reg_a[7:1]};
                carry_next = reg_a[0];
            end
            ALU_PASS_B: wide[7:0] = reg_b;
            default: wide = '0;
        endcase
    end

    assign alu_result = wide[7:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (load_flags) begin
            carry <= carry_next;
            zero  <= (wide[7:0] == '0);
        end
    end

endmodule

`default_nettype wire

//--- verilog/register_bank.sv
`timescale 1ns/10ps
`default_nettype none

module register_bank import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  out_rst,
    input  logic  load_a,
    input  logic  load_b,
    input  logic  load_out,
    input  byte_t main_bus,
    output byte_t reg_a,
    output byte_t reg_b,
    output byte_t out_port
);

    // Accumulator
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_a <= '0;
        end else if (load_a) begin
            reg_a <= main_bus;
        end
    end

    // Operand
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_b <= '0;
        end else if (load_b) begin
            reg_b <= main_bus;
        end
    end

    // Output port clear beats a load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_port <= '0;
        end else if (out_rst) begin
            out_port <= '0;
        end else if (load_out) begin
            out_port <= main_bus;
        end
    end

endmodule

`default_nettype wire

//--- verilog/control_decode.sv
`timescale 1ns/10ps
`default_nettype none

module control_decode import cpu_pkg::*; (
    input  ctrl_word_t ctrl_word,
    input  logic       ctrl_en,
    output bus_src_e   bus_src,
    output alu_op_e    alu_op,
    output logic       load_a,
    output logic       load_b,
    output logic       load_out,
    output logic       load_flags,
    output logic       mar_ext,
    output logic       mar_lo,
    output logic       mar_hi,
    output logic       mar_inc,
    output logic       ram_addr_ext,
    output logic       ram_we
);

    logic [CW_BUS_SRC_W-1:0] src_code;

    assign src_code = ctrl_word[CW_BUS_SRC_LSB +: CW_BUS_SRC_W];

    // Unknown source codes park the bus at zero
    always_comb begin
        if (!ctrl_en || src_code > BUS_OUT) begin
            bus_src = BUS_NONE;
        end else begin
            bus_src = bus_src_e'(src_code);
        end
    end

    // Only the flag strobe makes the op visible in state
    assign alu_op = alu_op_e'(ctrl_word[CW_ALU_OP_LSB +: CW_ALU_OP_W]);

    assign load_a       = ctrl_en & ctrl_word[CW_LOAD_A];
    assign load_b       = ctrl_en & ctrl_word[CW_LOAD_B];
    assign load_out     = ctrl_en & ctrl_word[CW_LOAD_OUT];
    assign load_flags   = ctrl_en & ctrl_word[CW_LOAD_FLAGS];
    assign mar_ext      = ctrl_en & ctrl_word[CW_MAR_EXT];
    assign mar_lo       = ctrl_en & ctrl_word[CW_MAR_LO];
    assign mar_hi       = ctrl_en & ctrl_word[CW_MAR_HI];
    assign mar_inc      = ctrl_en & ctrl_word[CW_MAR_INC];
    assign ram_we       = ctrl_en & ctrl_word[CW_RAM_WE];
    assign ram_addr_ext = ctrl_en & ctrl_word[CW_RAM_ADDR_EXT];

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [31:0] ctrl_word_t;

    // Main bus source select
    typedef enum logic [3:0] {
        BUS_NONE   = 4'd0,
        BUS_EXT    = 4'd1,
        BUS_A      = 4'd2,
        BUS_B      = 4'd3,
        BUS_ALU    = 4'd4,
        BUS_RAM    = 4'd5,
        BUS_MAR_LO = 4'd6,
        BUS_MAR_HI = 4'd7,
        BUS_OUT    = 4'd8
    } bus_src_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SHL    = 3'd5,
        ALU_SHR    = 3'd6,
        ALU_PASS_B = 3'd7
    } alu_op_e;

    // Control word fields
    localparam int CW_BUS_SRC_LSB = 0;
    localparam int CW_BUS_SRC_W   = 4;
    localparam int CW_ALU_OP_LSB  = 4;
    localparam int CW_ALU_OP_W    = 3;

    // Single-bit strobes
    localparam int CW_LOAD_A       = 7;
    localparam int CW_LOAD_B       = 8;
    localparam int CW_LOAD_OUT     = 9;
    localparam int CW_LOAD_FLAGS   = 10;
    localparam int CW_MAR_EXT      = 11;
    localparam int CW_MAR_LO       = 12;
    localparam int CW_MAR_HI       = 13;
    localparam int CW_MAR_INC      = 14;
    localparam int CW_RAM_WE       = 15;
    localparam int CW_RAM_ADDR_EXT = 16;

    // 1 KiB that aliases above the low address bits
    localparam int RAM_ADDR_BITS = 10;
    localparam int RAM_DEPTH     = 1 << RAM_ADDR_BITS;

endpackage

`default_nettype wire
